// File: hdl/stashScan_consts.svh
/* Tree, bucket and stash dimensions
   and the address widths derived from them */
`ifndef STASHSCAN_CONSTS_SVH
`define STASHSCAN_CONSTS_SVH

// Leaf label width, a path holds L+1 buckets
`define ORAM_L 4
// Blocks per bucket
`define ORAM_Z 4
// Stash depth in blocks
`define STASH_ENTRIES 16

// --------------------------------------------------
// Derived sizes
// --------------------------------------------------
`define ORAM_LEVELS (`ORAM_L + 1)
`define STASH_AWIDTH 4
// One table slot per block position on the path
`define SLOT_COUNT 20
`define TABLE_AWIDTH 5
`define LEVEL_WIDTH 3
// Must reach Z itself, not only Z-1
`define COUNT_WIDTH 3

`endif

// File: hdl/stashScanPkg.sv
/* Types shared by the stash scan datapath:
   tags, scan command, output slot and table placement */
`default_nettype none
`include "stashScan_consts.svh"

package stashScanPkg;

	// Bit i is the branch taken below level i
	typedef logic [`ORAM_L-1:0] leafT;
	typedef logic [`STASH_AWIDTH-1:0] stashAddrT;
	// Level 0 is the root bucket
	typedef logic [`LEVEL_WIDTH-1:0] levelT;
	typedef logic [$clog2(`ORAM_Z)-1:0] slotIdxT;
	typedef logic [`TABLE_AWIDTH-1:0] tableAddrT;
	// Bucket occupancy, 0 through Z
	typedef logic [`COUNT_WIDTH-1:0] countT;

	// Host tag write
	typedef struct packed {
		stashAddrT stashAddr;
		leafT leaf;
		logic valid;
	} entryWriteT;

	// Path being written back
	typedef struct packed {
		leafT leaf;
	} scanCmdT;

	// One bucket slot toward the host
	typedef struct packed {
		levelT level;
		slotIdxT slotIndex;
		stashAddrT sAddr;
		logic dummy;
	} slotT;

	// Table RAM write
	typedef struct packed {
		tableAddrT tableAddr;
		stashAddrT sAddr;
	} placementT;

endpackage

`default_nettype wire

// File: hdl/fourPhaseReceiver.sv
/* Four-phase req/ack receiver for any payload type */
`default_nettype none

module fourPhaseReceiver #(
	parameter type payloadT = logic
) (
	input wire logic Clock,
	input wire logic rst,
	input wire logic req,
	input wire payloadT payload,
	output logic ack,
	output payloadT captured,
	output logic strobe,
	input wire logic done
);

	logic reqQ;
	// Strobe issued, core not finished yet
	logic busy;
	logic reqRise;

	assign reqRise = req & ~reqQ;

	always_ff @(posedge Clock) begin
		if (rst) begin
			reqQ <= 1'b0;
			strobe <= 1'b0;
			busy <= 1'b0;
			ack <= 1'b0;
		end else begin
			reqQ <= req;
			strobe <= reqRise;
			if (reqRise)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			// Ack rises on done, falls once req is seen low
			if (busy && done)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

	// Payload held until the next request
	always_ff @(posedge Clock) begin
		if (reqRise)
			captured <= payload;
	end

	// Sender keeps req up until the core has answered
	assert property (@(posedge Clock) disable iff (rst) busy |-> req);

endmodule

`default_nettype wire

// File: hdl/stashTagStore.sv
/* Leaf and valid tags of the stash, indexed by stash address */
`default_nettype none
`include "stashScan_consts.svh"

module stashTagStore (
	input wire logic Clock,
	input wire logic rst,
	input wire stashScanPkg::entryWriteT write,
	input wire logic writeEn,
	input wire stashScanPkg::stashAddrT readAddr,
	output stashScanPkg::leafT readLeaf,
	output logic readValid
);

	stashScanPkg::leafT leafMem [`STASH_ENTRIES];
	logic [`STASH_ENTRIES-1:0] validBits;

	// Valid bits, all cleared by reset
	always_ff @(posedge Clock) begin
		if (rst)
			validBits <= '0;
		else if (writeEn)
			validBits[write.stashAddr] <= write.valid;
	end

	// Leaf labels
	always_ff @(posedge Clock) begin
		if (writeEn)
			leafMem[write.stashAddr] <= write.leaf;
	end

	// Combinational read for the scan walk
	assign readLeaf = leafMem[readAddr];
	assign readValid = validBits[readAddr];

endmodule

`default_nettype wire

// File: hdl/scanCounter.sv
/* Shared walk counter with run-time limit */
`default_nettype none

module scanCounter (
	input wire logic Clock,
	input wire logic rst,
	input wire logic clear,
	input wire logic step,
	input wire stashScanPkg::tableAddrT limit,
	output stashScanPkg::tableAddrT count,
	output logic last
);

	always_ff @(posedge Clock) begin
		if (rst || clear)
			count <= '0;
		else if (step)
			count <= count + 1'b1;
	end

	// Final position of the current walk
	assign last = (count == limit - 1'b1);

	// Walks never run past their limit
	assert property (@(posedge Clock) disable iff (rst) !(step && last && !clear));

endmodule

`default_nettype wire

// File: hdl/stashScanFsm.sv
/* Sequencer for tag loads, the entry walk and the slot readout */
`default_nettype none
`include "stashScan_consts.svh"

module stashScanFsm (
	input wire logic Clock,
	input wire logic rst,
	input wire logic entryStrobe,
	input wire logic scanStrobe,
	output logic entryDone,
	output logic scanDone,
	output logic cntClear,
	output logic cntStep,
	output stashScanPkg::tableAddrT cntLimit,
	input wire logic cntLast,
	output logic tableClear,
	output logic scanValid,
	output logic readEn,
	input wire logic slotBusy
);

	typedef enum logic [2:0] {
		sIdle, sEntryWrite, sClear, sScan, sReadWait, sReadout, sFinish
	} stateT;

	stateT state, nextState;
	// Scan strobe that landed during a tag write
	logic scanPend;

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= sIdle;
			scanPend <= 1'b0;
		end else begin
			state <= nextState;
			if (scanStrobe && state != sIdle)
				scanPend <= 1'b1;
			else if (state == sClear)
				scanPend <= 1'b0;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			// Scan wins over a waiting tag write
			sIdle:
				if (scanStrobe || scanPend)
					nextState = sClear;
				else if (entryStrobe)
					nextState = sEntryWrite;
			sEntryWrite: nextState = sIdle;
			sClear: nextState = sScan;
			sScan:
				if (cntLast)
					nextState = sReadWait;
			// RAM read in flight
			sReadWait: nextState = sReadout;
			// Hold the slot until the host has taken it
			sReadout:
				if (!slotBusy)
					nextState = cntLast ? sFinish : sReadWait;
			sFinish: nextState = sIdle;
			default: nextState = sIdle;
		endcase
	end

	assign entryDone = (state == sEntryWrite);
	assign scanDone = (state == sFinish);
	assign tableClear = (state == sClear);
	assign scanValid = (state == sScan);
	assign readEn = (state == sReadWait);

	// Counter restarts for the slot walk on the last entry
	assign cntClear = (state == sClear) || (state == sScan && cntLast);
	assign cntStep = (state == sScan && !cntLast) ||
		(state == sReadout && !slotBusy && !cntLast);
	assign cntLimit = (state == sClear || state == sScan) ?
		stashScanPkg::tableAddrT'(`STASH_ENTRIES) : stashScanPkg::tableAddrT'(`SLOT_COUNT);

endmodule

`default_nettype wire

// File: hdl/stashScanTable.sv
/* Deepest-fit placement on the current path, bucket occupancy
   counters and the placement table RAM */
`default_nettype none
`include "stashScan_consts.svh"

module stashScanTable (
	input wire logic Clock,
	input wire logic rst,
	input wire logic clear,
	input wire stashScanPkg::leafT currentLeaf,
	input wire stashScanPkg::leafT inLeaf,
	input wire stashScanPkg::stashAddrT inSAddr,
	input wire logic inValid,
	input wire logic readEn,
	input wire stashScanPkg::tableAddrT readAddr,
	output logic accepted,
	output stashScanPkg::stashAddrT readSAddr,
	output logic readFilled
);

	logic [`ORAM_LEVELS-1:0] diffBits;
	logic [`ORAM_LEVELS-1:0] commonPath;
	logic [`ORAM_LEVELS-1:0] fullMask;
	logic [`ORAM_LEVELS-1:0] spaceMask;
	stashScanPkg::countT occupancy [`ORAM_LEVELS];
	stashScanPkg::levelT deepest;
	stashScanPkg::placementT place;
	stashScanPkg::stashAddrT tableRam [`SLOT_COUNT];
	stashScanPkg::levelT rdLevel;
	stashScanPkg::slotIdxT rdSlot;

	// --------------------------------------------------
	// Path intersection
	// --------------------------------------------------
	// Appended root bit never differs
	assign diffBits = {inLeaf, 1'b0} ^ {currentLeaf, 1'b0};
	// Ones below the lowest differing bit, all ones on a full match
	assign commonPath = ~(diffBits | -diffBits);

	always_comb begin
		for (int lvl = 0; lvl < `ORAM_LEVELS; lvl++)
			fullMask[lvl] = (occupancy[lvl] == `ORAM_Z);
	end

	assign spaceMask = commonPath & ~fullMask;

	// Deepest common level with room
	always_comb begin
		deepest = '0;
		for (int lvl = 0; lvl < `ORAM_LEVELS; lvl++)
			if (spaceMask[lvl])
				deepest = stashScanPkg::levelT'(lvl);
	end

	assign accepted = inValid & |spaceMask;
	// Level base plus slots already used there
	assign place.tableAddr = stashScanPkg::tableAddrT'(deepest * `ORAM_Z + occupancy[deepest]);
	assign place.sAddr = inSAddr;

	// --------------------------------------------------
	// Occupancy and table RAM
	// --------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst || clear) begin
			for (int lvl = 0; lvl < `ORAM_LEVELS; lvl++)
				occupancy[lvl] <= '0;
		end else if (accepted) begin
			occupancy[deepest] <= occupancy[deepest] + 1'b1;
		end
	end

	// Readout address split into level and slot
	assign rdLevel = stashScanPkg::levelT'(readAddr / `ORAM_Z);
	assign rdSlot = stashScanPkg::slotIdxT'(readAddr % `ORAM_Z);

	always_ff @(posedge Clock) begin
		if (accepted)
			tableRam[place.tableAddr] <= place.sAddr;
		// Slots past the level count hold stale data
		if (readEn) begin
			readSAddr <= tableRam[readAddr];
			readFilled <= (rdSlot < occupancy[rdLevel]);
		end
	end

	// Full buckets are masked before each increment
	for (genvar lvl = 0; lvl < `ORAM_LEVELS; lvl++) begin : gOccCheck
		assert property (@(posedge Clock) disable iff (rst) occupancy[lvl] <= `ORAM_Z);
	end

endmodule

`default_nettype wire

// File: hdl/evictionSender.sv
/* Builds slot records from table read data and sends them
   over a four-phase req/ack port */
`default_nettype none
`include "stashScan_consts.svh"

module evictionSender (
	input wire logic Clock,
	input wire logic rst,
	input wire stashScanPkg::stashAddrT readSAddr,
	input wire logic readFilled,
	input wire stashScanPkg::tableAddrT slotAddr,
	input wire logic dataValid,
	output logic slotReq,
	input wire logic slotAck,
	output stashScanPkg::slotT slot,
	output logic busy
);

	typedef enum logic [1:0] {pIdle, pRequest, pRelease} phaseT;

	phaseT phase;

	// Handshake sequencing
	always_ff @(posedge Clock) begin
		if (rst) begin
			phase <= pIdle;
			slotReq <= 1'b0;
		end else begin
			case (phase)
				pIdle:
					if (dataValid) begin
						phase <= pRequest;
						slotReq <= 1'b1;
					end
				pRequest:
					if (slotAck) begin
						phase <= pRelease;
						slotReq <= 1'b0;
					end
				// Wait for the host to drop ack
				pRelease:
					if (!slotAck)
						phase <= pIdle;
				default: phase <= pIdle;
			endcase
		end
	end

	// Slot record, latched with the read data
	always_ff @(posedge Clock) begin
		if (dataValid) begin
			slot.level <= stashScanPkg::levelT'(slotAddr / `ORAM_Z);
			slot.slotIndex <= stashScanPkg::slotIdxT'(slotAddr % `ORAM_Z);
			slot.sAddr <= readSAddr;
			slot.dummy <= ~readFilled;
		end
	end

	assign busy = dataValid | (phase != pIdle);

	// Record stays put while the host has not answered
	assert property (@(posedge Clock) disable iff (rst) slotReq && !slotAck |=> $stable(slot));

endmodule

`default_nettype wire

// File: hdl/stashScanTop.sv
/* Stash scan controller top: host ports, tag store,
   sequencer, placement table and slot sender */
`default_nettype none

module stashScanTop (
	input wire logic Clock,
	input wire logic rst,
	input wire logic entryReq,
	input wire stashScanPkg::entryWriteT entry,
	output logic entryAck,
	input wire logic scanReq,
	input wire stashScanPkg::scanCmdT scanCmd,
	output logic scanAck,
	output logic slotReq,
	input wire logic slotAck,
	output stashScanPkg::slotT slot
);

	stashScanPkg::entryWriteT entryCaptured;
	stashScanPkg::scanCmdT scanCaptured;
	stashScanPkg::tableAddrT cntLimit;
	stashScanPkg::tableAddrT count;
	stashScanPkg::leafT tagLeaf;
	stashScanPkg::stashAddrT readSAddr;
	logic entryRxStrobe, entryStrobe, scanStrobe;
	logic entryDone, scanDone;
	logic entryWait, scanOpen;
	logic cntClear, cntStep, cntLast;
	logic tableClear, scanValid, readEn, dataValid;
	logic tagValid, readFilled, slotBusy;

	// --------------------------------------------------
	// Host request ports
	// --------------------------------------------------
	fourPhaseReceiver #(.payloadT(stashScanPkg::entryWriteT)) entryRx (
		.Clock(Clock), .rst(rst), .req(entryReq), .payload(entry), .ack(entryAck),
		.captured(entryCaptured), .strobe(entryRxStrobe), .done(entryDone)
	);

	fourPhaseReceiver #(.payloadT(stashScanPkg::scanCmdT)) scanRx (
		.Clock(Clock), .rst(rst), .req(scanReq), .payload(scanCmd), .ack(scanAck),
		.captured(scanCaptured), .strobe(scanStrobe), .done(scanDone)
	);

	// Tag writes wait while a scan handshake is open
	always_ff @(posedge Clock) begin
		if (rst) begin
			scanOpen <= 1'b0;
			entryWait <= 1'b0;
			dataValid <= 1'b0;
		end else begin
			if (scanStrobe)
				scanOpen <= 1'b1;
			else if (scanAck && !scanReq)
				scanOpen <= 1'b0;
			if (entryDone)
				entryWait <= 1'b0;
			else if (entryRxStrobe)
				entryWait <= 1'b1;
			// Table read data valid one cycle after readEn
			dataValid <= readEn;
		end
	end

	assign entryStrobe = (entryRxStrobe | entryWait) & ~scanOpen;

	// --------------------------------------------------
	// Core blocks
	// --------------------------------------------------
	stashTagStore tags (
		.Clock(Clock), .rst(rst), .write(entryCaptured), .writeEn(entryDone),
		.readAddr(stashScanPkg::stashAddrT'(count)), .readLeaf(tagLeaf), .readValid(tagValid)
	);

	scanCounter walk (
		.Clock(Clock), .rst(rst), .clear(cntClear), .step(cntStep),
		.limit(cntLimit), .count(count), .last(cntLast)
	);

	stashScanFsm fsm (
		.Clock(Clock), .rst(rst), .entryStrobe(entryStrobe), .scanStrobe(scanStrobe),
		.entryDone(entryDone), .scanDone(scanDone), .cntClear(cntClear), .cntStep(cntStep),
		.cntLimit(cntLimit), .cntLast(cntLast), .tableClear(tableClear),
		.scanValid(scanValid), .readEn(readEn), .slotBusy(slotBusy)
	);

	// Placement result stays inside the table
	stashScanTable scanTable (
		.Clock(Clock), .rst(rst), .clear(tableClear), .currentLeaf(scanCaptured.leaf),
		.inLeaf(tagLeaf), .inSAddr(stashScanPkg::stashAddrT'(count)),
		.inValid(scanValid & tagValid), .readEn(readEn), .readAddr(count),
		.accepted(), .readSAddr(readSAddr), .readFilled(readFilled)
	);

	evictionSender sender (
		.Clock(Clock), .rst(rst), .readSAddr(readSAddr), .readFilled(readFilled),
		.slotAddr(count), .dataValid(dataValid), .slotReq(slotReq), .slotAck(slotAck),
		.slot(slot), .busy(slotBusy)
	);

endmodule

`default_nettype wire

// File: bench/stashScanTb.sv
/* Testbench for the stash scan controller: clock, reset, watchdog,
   placement model, compare tasks and directed tests */
`default_nettype none
`include "stashScan_consts.svh"

module stashScanTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 40;
	localparam int TESTS = 6;

	logic Clock;
	logic rst;
	logic entryReq, entryAck, scanReq, scanAck, slotReq, slotAck;
	stashScanPkg::entryWriteT entry;
	stashScanPkg::scanCmdT scanCmd;
	stashScanPkg::slotT slot;

	// Tag image as the host wrote it
	stashScanPkg::leafT modelLeaf [`STASH_ENTRIES];
	logic modelValid [`STASH_ENTRIES];
	stashScanPkg::slotT expSlots [`SLOT_COUNT];
	stashScanPkg::slotT gotSlots [`SLOT_COUNT];
	int errors, testsFailed, errAtStart;
	time scanFallTime, entryAckTime;
	stashScanPkg::leafT randLeaf;

	stashScanTop dut0 (
		.Clock(Clock), .rst(rst), .entryReq(entryReq), .entry(entry), .entryAck(entryAck),
		.scanReq(scanReq), .scanCmd(scanCmd), .scanAck(scanAck),
		.slotReq(slotReq), .slotAck(slotAck), .slot(slot)
	);

	initial begin
		Clock = 1'b0;
		forever #(PERIOD / 2) Clock = ~Clock;
	end

	// Bound of 2000 cycles per test
	initial begin
		#(TESTS * 2000 * PERIOD);
		$display("Watchdog expired, the DUT stopped answering a handshake");
		$display("STATUS: FAIL");
		$finish;
	end

	// --------------------------------------------------
	// Handshake helpers
	// --------------------------------------------------
	// Drive and sample point, 5 ns past the edge
	task automatic nextCycle();
		@(posedge Clock);
		#5;
	endtask

	task automatic writeEntry(input stashScanPkg::stashAddrT addr,
			input stashScanPkg::leafT leaf, input logic valid);
		entry.stashAddr = addr;
		entry.leaf = leaf;
		entry.valid = valid;
		entryReq = 1'b1;
		while (!entryAck)
			nextCycle();
		entryReq = 1'b0;
		while (entryAck)
			nextCycle();
		modelLeaf[addr] = leaf;
		modelValid[addr] = valid;
	endtask

	task automatic clearTags();
		for (int a = 0; a < `STASH_ENTRIES; a++)
			writeEntry(stashScanPkg::stashAddrT'(a), '0, 1'b0);
	endtask

	// Host side of the slot port, 0 to 3 cycles before each ack
	task automatic collectSlots();
		int delay;
		for (int s = 0; s < `SLOT_COUNT; s++) begin
			while (!slotReq)
				nextCycle();
			gotSlots[s] = slot;
			delay = int'($urandom % 4);
			repeat (delay)
				nextCycle();
			slotAck = 1'b1;
			while (slotReq)
				nextCycle();
			slotAck = 1'b0;
		end
	endtask

	// --------------------------------------------------
	// Placement model
	// --------------------------------------------------
	task automatic buildModel(input stashScanPkg::leafT cur);
		int fill [`ORAM_LEVELS];
		int k;
		int lvl;
		for (int l = 0; l < `ORAM_LEVELS; l++)
			fill[l] = 0;
		for (int s = 0; s < `SLOT_COUNT; s++) begin
			expSlots[s].level = stashScanPkg::levelT'(s / `ORAM_Z);
			expSlots[s].slotIndex = stashScanPkg::slotIdxT'(s % `ORAM_Z);
			expSlots[s].sAddr = '0;
			expSlots[s].dummy = 1'b1;
		end
		for (int a = 0; a < `STASH_ENTRIES; a++) begin
			if (modelValid[a]) begin
				// Shared levels end at the first differing low bit
				k = 0;
				while (k < `ORAM_L && modelLeaf[a][k] == cur[k])
					k++;
				lvl = k;
				while (lvl >= 0 && fill[lvl] == `ORAM_Z)
					lvl--;
				// Nowhere to go, stays in the stash
				if (lvl >= 0) begin
					expSlots[lvl * `ORAM_Z + fill[lvl]].sAddr = stashScanPkg::stashAddrT'(a);
					expSlots[lvl * `ORAM_Z + fill[lvl]].dummy = 1'b0;
					fill[lvl]++;
				end
			end
		end
	endtask

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic compareSlot(input stashScanPkg::slotT got, input stashScanPkg::slotT exp,
			input int idx);
		stashScanPkg::slotT gotCmp;
		gotCmp = got;
		// Address of a dummy slot is stale
		if (exp.dummy)
			gotCmp.sAddr = exp.sAddr;
		if (gotCmp !== exp) begin
			errors++;
			$display("MISMATCH t=%0t slot[%0d] got %h exp %h", $time, idx, got, exp);
		end
	endtask

	task automatic compareLevel(input stashScanPkg::levelT lvl, input stashScanPkg::countT got,
			input stashScanPkg::countT exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t dummyCount[level %0d] got %0d exp %0d",
				$time, lvl, got, exp);
		end
	endtask

	task automatic checkSlots();
		int gotDummy;
		int expDummy;
		for (int s = 0; s < `SLOT_COUNT; s++)
			compareSlot(gotSlots[s], expSlots[s], s);
		for (int l = 0; l < `ORAM_LEVELS; l++) begin
			gotDummy = 0;
			expDummy = 0;
			for (int j = 0; j < `ORAM_Z; j++) begin
				gotDummy += int'(gotSlots[l * `ORAM_Z + j].dummy);
				expDummy += int'(expSlots[l * `ORAM_Z + j].dummy);
			end
			compareLevel(stashScanPkg::levelT'(l), stashScanPkg::countT'(gotDummy),
				stashScanPkg::countT'(expDummy));
		end
	endtask

	// Full scan handshake, slots checked against the model
	task automatic runScan(input stashScanPkg::leafT cur);
		buildModel(cur);
		scanCmd.leaf = cur;
		scanReq = 1'b1;
		collectSlots();
		while (!scanAck)
			nextCycle();
		scanReq = 1'b0;
		while (scanAck)
			nextCycle();
		scanFallTime = $time;
		checkSlots();
	endtask

	task automatic endTest(input int num, input string name);
		if (errors == errAtStart) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - errAtStart);
		end
		errAtStart = errors;
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic testEmptyScan();
		compareFlag("entryAck", entryAck, 1'b0);
		compareFlag("scanAck", scanAck, 1'b0);
		compareFlag("slotReq", slotReq, 1'b0);
		runScan(4'h5);
		endTest(1, "reset and empty scan");
	endtask

	task automatic testSingleEntry();
		clearTags();
		writeEntry(4'd7, 4'h9, 1'b1);
		runScan(4'h9);
		endTest(2, "single entry at leaf");
	endtask

	// Four fill level 4, the rest spill to level 3
	task automatic testBucketOverflow();
		clearTags();
		writeEntry(4'd2, 4'hc, 1'b1);
		writeEntry(4'd4, 4'hc, 1'b1);
		writeEntry(4'd5, 4'hc, 1'b1);
		writeEntry(4'd7, 4'hc, 1'b1);
		writeEntry(4'd9, 4'hc, 1'b1);
		writeEntry(4'd12, 4'hc, 1'b1);
		runScan(4'hc);
		endTest(3, "leaf bucket overflow");
	endtask

	// Bit 0 differs from path 6, root only
	task automatic testRootContention();
		clearTags();
		writeEntry(4'd1, 4'h1, 1'b1);
		writeEntry(4'd3, 4'h3, 1'b1);
		writeEntry(4'd6, 4'h5, 1'b1);
		writeEntry(4'd8, 4'hb, 1'b1);
		writeEntry(4'd10, 4'hf, 1'b1);
		runScan(4'h6);
		for (int s = 0; s < `SLOT_COUNT; s++)
			if (!gotSlots[s].dummy && gotSlots[s].sAddr == 4'd10) begin
				errors++;
				$display("Dropped entry 10 was emitted in slot %0d", s);
			end
		endTest(4, "root contention");
	endtask

	task automatic testRandomLeaves();
		randLeaf = stashScanPkg::leafT'($urandom);
		for (int a = 0; a < `STASH_ENTRIES; a++)
			writeEntry(stashScanPkg::stashAddrT'(a), stashScanPkg::leafT'($urandom), 1'b1);
		runScan(randLeaf);
		endTest(5, "random leaves");
	endtask

	task automatic testRescan();
		for (int a = 1; a < `STASH_ENTRIES; a += 2)
			writeEntry(stashScanPkg::stashAddrT'(a), modelLeaf[a], 1'b0);
		fork
			runScan(randLeaf);
			// Tag write raised in the middle of the entry walk
			begin
				repeat (10)
					nextCycle();
				entry.stashAddr = 4'd1;
				entry.leaf = randLeaf;
				entry.valid = 1'b1;
				entryReq = 1'b1;
				while (!entryAck)
					nextCycle();
				entryAckTime = $time;
				entryReq = 1'b0;
				while (entryAck)
					nextCycle();
			end
		join
		if (entryAckTime <= scanFallTime) begin
			errors++;
			$display("Entry write was acked while the scan handshake was still open");
		end
		modelLeaf[1] = randLeaf;
		modelValid[1] = 1'b1;
		runScan(randLeaf);
		endTest(6, "invalidate and rescan");
	endtask

	initial begin
		void'($urandom(32'h95244370));
		rst = 1'b1;
		entryReq = 1'b0;
		entry = '0;
		scanReq = 1'b0;
		scanCmd = '0;
		slotAck = 1'b0;
		errors = 0;
		testsFailed = 0;
		errAtStart = 0;
		for (int a = 0; a < `STASH_ENTRIES; a++) begin
			modelLeaf[a] = '0;
			modelValid[a] = 1'b0;
		end
		repeat (8)
			@(posedge Clock);
		#5;
		rst = 1'b0;
		testEmptyScan();
		testSingleEntry();
		testBucketOverflow();
		testRootContention();
		testRandomLeaves();
		testRescan();
		$display("Tests run %0d, failed %0d, errors %0d", TESTS, testsFailed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: stashScan.f
+incdir+hdl
hdl/stashScanPkg.sv
hdl/fourPhaseReceiver.sv
hdl/stashTagStore.sv
hdl/scanCounter.sv
hdl/stashScanFsm.sv
hdl/stashScanTable.sv
hdl/evictionSender.sv
hdl/stashScanTop.sv
bench/stashScanTb.sv

// File: Makefile
# Verilator build and run for the stash scan controller
TOP := stashScanTb

all: run

# Build, run, and pass only when the testbench reports a pass
run:
	verilator --binary --timing --assert -Wno-fatal -f stashScan.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --timing -f stashScan.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
